// File: hw/axi_mem_pkg.sv
`default_nettype none

package axi_mem_pkg;

  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 64;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;
  localparam int WORD_LSB   = $clog2(AXI_STRB_W);  // byte offset bits inside a beat

  // 256 words of 8 bytes, mapped from address 0
  localparam int MEM_WORDS = 256;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [AXI_DATA_W-1:0] axi_data_t;
  typedef logic [AXI_STRB_W-1:0] axi_strb_t;

  localparam axi_addr_t BEAT_BYTES = axi_addr_t'(AXI_STRB_W);  // address step per beat

  typedef struct packed {
    axi_addr_t  addr;
    logic [2:0] prot;
    logic       len;    // 0 = one beat, 1 = two beats
    logic [2:0] size;
    logic [1:0] burst;
  } axi_aw_t;

  // read address carries the same fields
  typedef axi_aw_t axi_ar_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } axi_w_t;

  typedef struct packed {
    axi_resp_e resp;
  } axi_b_t;

  typedef struct packed {
    axi_data_t data;
    axi_resp_e resp;
    logic      last;
  } axi_r_t;

endpackage

`default_nettype wire

// File: hw/sram_array.sv
`default_nettype none

module sram_array #(
  parameter int DEPTH = axi_mem_pkg::MEM_WORDS
) (
  input  wire logic                   clk,
  input  wire logic                   we_i,
  input  wire logic [$clog2(DEPTH)-1:0] waddr_i,
  input  wire axi_mem_pkg::axi_data_t wdata_i,
  input  wire axi_mem_pkg::axi_strb_t wstrb_i,
  input  wire logic [$clog2(DEPTH)-1:0] raddr_i,
  output axi_mem_pkg::axi_data_t      rdata_o
);
  import axi_mem_pkg::*;

  axi_data_t mem [DEPTH];

  // byte lanes written only where the strobe is set
  always_ff @(posedge clk) begin
    if (we_i) begin
      for (int b = 0; b < AXI_STRB_W; b++) begin
        if (wstrb_i[b]) begin
          mem[waddr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  assign rdata_o = mem[raddr_i];  // async read

endmodule

`default_nettype wire

// File: hw/axi_sram_slave.sv
`default_nettype none

module axi_sram_slave #(
  parameter int DEPTH = axi_mem_pkg::MEM_WORDS
) (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 aw_valid_i,
  input  wire axi_mem_pkg::axi_aw_t aw_i,
  output logic                      aw_ready_o,
  input  wire logic                 w_valid_i,
  input  wire axi_mem_pkg::axi_w_t  w_i,
  output logic                      w_ready_o,
  output logic                      b_valid_o,
  output axi_mem_pkg::axi_b_t       b_o,
  input  wire logic                 b_ready_i,
  input  wire logic                 ar_valid_i,
  input  wire axi_mem_pkg::axi_ar_t ar_i,
  output logic                      ar_ready_o,
  output logic                      r_valid_o,
  output axi_mem_pkg::axi_r_t       r_o,
  input  wire logic                 r_ready_i
);
  import axi_mem_pkg::*;

  localparam int IDX_W = $clog2(DEPTH);
  localparam int WIDX_W = AXI_ADDR_W - WORD_LSB;
  localparam logic [WIDX_W-1:0] WORD_LIMIT = WIDX_W'(DEPTH);

  typedef enum logic [1:0] {W_IDLE, W_DATA, W_RESP} wstate_e;
  typedef enum logic {R_IDLE, R_DATA} rstate_e;

  wstate_e           wstate_q;
  axi_addr_t         waddr_q;
  logic              wlen_q;   // beats left after the current one
  logic              werr_q;   // sticky on any beat out of range

  rstate_e           rstate_q;
  axi_addr_t         raddr_q;  // address of the next beat to load
  logic              rlen_q;
  axi_r_t            r_q;

  logic              aw_fire;
  logic              w_fire;
  logic              b_fire;
  logic              ar_fire;
  logic              r_fire;
  logic              r_load;
  logic [WIDX_W-1:0] w_idx;
  logic [WIDX_W-1:0] r_idx;
  logic              w_hit;
  logic              r_hit;
  axi_addr_t         rd_addr;
  axi_data_t         rd_word;

  assign aw_ready_o = (wstate_q == W_IDLE);
  assign w_ready_o  = (wstate_q == W_DATA);
  assign b_valid_o  = (wstate_q == W_RESP);
  assign b_o.resp   = werr_q ? RESP_SLVERR : RESP_OKAY;

  assign ar_ready_o = (rstate_q == R_IDLE);
  assign r_valid_o  = (rstate_q == R_DATA);
  assign r_o        = r_q;

  assign aw_fire = aw_valid_i & aw_ready_o;
  assign w_fire  = w_valid_i & w_ready_o;
  assign b_fire  = b_valid_o & b_ready_i;
  assign ar_fire = ar_valid_i & ar_ready_o;
  assign r_fire  = r_valid_o & r_ready_i;

  assign w_idx = waddr_q[AXI_ADDR_W-1:WORD_LSB];
  assign w_hit = (w_idx < WORD_LIMIT);

  // first beat comes straight from the ar payload
  assign rd_addr = (rstate_q == R_IDLE) ? ar_i.addr : raddr_q;
  assign r_idx   = rd_addr[AXI_ADDR_W-1:WORD_LSB];
  assign r_hit   = (r_idx < WORD_LIMIT);
  assign r_load  = ar_fire | (r_fire & (rlen_q != 1'b0));

  sram_array #(
    .DEPTH(DEPTH)
  ) mem0 (
    .clk    (clk),
    .we_i   (w_fire & w_hit),  // out of range writes dropped
    .waddr_i(w_idx[IDX_W-1:0]),
    .wdata_i(w_i.data),
    .wstrb_i(w_i.strb),
    .raddr_i(r_idx[IDX_W-1:0]),
    .rdata_o(rd_word)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      wstate_q <= W_IDLE;
      waddr_q  <= '0;
      wlen_q   <= 1'b0;
      werr_q   <= 1'b0;
    end else begin
      case (wstate_q)
        W_IDLE: begin
          if (aw_fire) begin
            wstate_q <= W_DATA;
            waddr_q  <= aw_i.addr;
            wlen_q   <= aw_i.len;
            werr_q   <= 1'b0;
          end
        end
        W_DATA: begin
          if (w_fire) begin
            werr_q <= werr_q | ~w_hit;
            if (wlen_q == 1'b0) begin
              wstate_q <= W_RESP;
            end else begin
              wlen_q  <= wlen_q - 1'b1;
              waddr_q <= waddr_q + BEAT_BYTES;
            end
          end
        end
        W_RESP: begin
          if (b_fire) wstate_q <= W_IDLE;
        end
        default: wstate_q <= W_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rstate_q <= R_IDLE;
      raddr_q  <= '0;
      rlen_q   <= 1'b0;
    end else begin
      case (rstate_q)
        R_IDLE: begin
          if (ar_fire) begin
            rstate_q <= R_DATA;
            raddr_q  <= ar_i.addr + BEAT_BYTES;
            rlen_q   <= ar_i.len;
          end
        end
        R_DATA: begin
          if (r_fire) begin
            if (rlen_q != 1'b0) begin
              rlen_q  <= rlen_q - 1'b1;
              raddr_q <= raddr_q + BEAT_BYTES;
            end else begin
              rstate_q <= R_IDLE;
            end
          end
        end
        default: rstate_q <= R_IDLE;
      endcase
    end
  end

  // r beat register loaded on ar accept and on each non-final r handshake
  always_ff @(posedge clk) begin
    if (r_load) begin
      r_q.data <= r_hit ? rd_word : '0;
      r_q.resp <= r_hit ? RESP_OKAY : RESP_SLVERR;
      r_q.last <= (rstate_q == R_IDLE) ? (ar_i.len == 1'b0) : (rlen_q == 1'b1);
    end
  end

  a_wlast_matches_len: assert property (@(posedge clk) disable iff (rst)
    w_fire |-> (w_i.last == (wlen_q == 1'b0)))
    else $error("w.last disagrees with the burst length");

  a_r_stable: assert property (@(posedge clk) disable iff (rst)
    (r_valid_o && !r_ready_i) |=> (r_valid_o && $stable(r_o)))
    else $error("r beat changed under back-pressure");

endmodule

`default_nettype wire

// File: hw/axi_arbiter.sv
`default_nettype none

module axi_arbiter (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 m0_aw_valid_i,
  input  wire axi_mem_pkg::axi_aw_t m0_aw_i,
  output logic                      m0_aw_ready_o,
  input  wire logic                 m0_w_valid_i,
  input  wire axi_mem_pkg::axi_w_t  m0_w_i,
  output logic                      m0_w_ready_o,
  output logic                      m0_b_valid_o,
  output axi_mem_pkg::axi_b_t       m0_b_o,
  input  wire logic                 m0_b_ready_i,
  input  wire logic                 m0_ar_valid_i,
  input  wire axi_mem_pkg::axi_ar_t m0_ar_i,
  output logic                      m0_ar_ready_o,
  output logic                      m0_r_valid_o,
  output axi_mem_pkg::axi_r_t       m0_r_o,
  input  wire logic                 m0_r_ready_i,
  input  wire logic                 m1_aw_valid_i,
  input  wire axi_mem_pkg::axi_aw_t m1_aw_i,
  output logic                      m1_aw_ready_o,
  input  wire logic                 m1_w_valid_i,
  input  wire axi_mem_pkg::axi_w_t  m1_w_i,
  output logic                      m1_w_ready_o,
  output logic                      m1_b_valid_o,
  output axi_mem_pkg::axi_b_t       m1_b_o,
  input  wire logic                 m1_b_ready_i,
  input  wire logic                 m1_ar_valid_i,
  input  wire axi_mem_pkg::axi_ar_t m1_ar_i,
  output logic                      m1_ar_ready_o,
  output logic                      m1_r_valid_o,
  output axi_mem_pkg::axi_r_t       m1_r_o,
  input  wire logic                 m1_r_ready_i,
  output logic                      s_aw_valid_o,
  output axi_mem_pkg::axi_aw_t      s_aw_o,
  input  wire logic                 s_aw_ready_i,
  output logic                      s_w_valid_o,
  output axi_mem_pkg::axi_w_t       s_w_o,
  input  wire logic                 s_w_ready_i,
  input  wire logic                 s_b_valid_i,
  input  wire axi_mem_pkg::axi_b_t  s_b_i,
  output logic                      s_b_ready_o,
  output logic                      s_ar_valid_o,
  output axi_mem_pkg::axi_ar_t      s_ar_o,
  input  wire logic                 s_ar_ready_i,
  input  wire logic                 s_r_valid_i,
  input  wire axi_mem_pkg::axi_r_t  s_r_i,
  output logic                      s_r_ready_o
);
  import axi_mem_pkg::*;

  // 1 selects m1; prefer1 breaks the tie when both request
  function automatic logic rr_pick(logic req0, logic req1, logic prefer1);
    return (req0 && req1) ? prefer1 : req1;
  endfunction

  logic wbusy_q, wgnt_q, wrr_q;
  logic rbusy_q, rgnt_q, rrr_q;
  logic wpick, rpick;
  logic w_done, r_done;

  assign wpick  = rr_pick(m0_aw_valid_i, m1_aw_valid_i, wrr_q);
  assign rpick  = rr_pick(m0_ar_valid_i, m1_ar_valid_i, rrr_q);
  assign w_done = s_b_valid_i & s_b_ready_o;
  assign r_done = s_r_valid_i & s_r_ready_o & s_r_i.last;

  always_ff @(posedge clk) begin
    if (rst) begin
      wbusy_q <= 1'b0;
      wgnt_q  <= 1'b0;
      wrr_q   <= 1'b0;  // m0 first
    end else if (!wbusy_q) begin
      if (m0_aw_valid_i || m1_aw_valid_i) begin
        wbusy_q <= 1'b1;
        wgnt_q  <= wpick;
        wrr_q   <= ~wpick;
      end
    end else if (w_done) begin
      wbusy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rbusy_q <= 1'b0;
      rgnt_q  <= 1'b0;
      rrr_q   <= 1'b0;
    end else if (!rbusy_q) begin
      if (m0_ar_valid_i || m1_ar_valid_i) begin
        rbusy_q <= 1'b1;
        rgnt_q  <= rpick;
        rrr_q   <= ~rpick;
      end
    end else if (r_done) begin
      rbusy_q <= 1'b0;
    end
  end

  // write side
  assign s_aw_valid_o = wbusy_q & (wgnt_q ? m1_aw_valid_i : m0_aw_valid_i);
  assign s_aw_o       = wgnt_q ? m1_aw_i : m0_aw_i;
  assign s_w_valid_o  = wbusy_q & (wgnt_q ? m1_w_valid_i : m0_w_valid_i);
  assign s_w_o        = wgnt_q ? m1_w_i : m0_w_i;
  assign s_b_ready_o  = wbusy_q & (wgnt_q ? m1_b_ready_i : m0_b_ready_i);

  assign m0_aw_ready_o = wbusy_q & ~wgnt_q & s_aw_ready_i;
  assign m1_aw_ready_o = wbusy_q & wgnt_q & s_aw_ready_i;
  assign m0_w_ready_o  = wbusy_q & ~wgnt_q & s_w_ready_i;
  assign m1_w_ready_o  = wbusy_q & wgnt_q & s_w_ready_i;
  assign m0_b_valid_o  = wbusy_q & ~wgnt_q & s_b_valid_i;
  assign m1_b_valid_o  = wbusy_q & wgnt_q & s_b_valid_i;
  assign m0_b_o        = s_b_i;  // qualified by b_valid
  assign m1_b_o        = s_b_i;

  // read side
  assign s_ar_valid_o = rbusy_q & (rgnt_q ? m1_ar_valid_i : m0_ar_valid_i);
  assign s_ar_o       = rgnt_q ? m1_ar_i : m0_ar_i;
  assign s_r_ready_o  = rbusy_q & (rgnt_q ? m1_r_ready_i : m0_r_ready_i);

  assign m0_ar_ready_o = rbusy_q & ~rgnt_q & s_ar_ready_i;
  assign m1_ar_ready_o = rbusy_q & rgnt_q & s_ar_ready_i;
  assign m0_r_valid_o  = rbusy_q & ~rgnt_q & s_r_valid_i;
  assign m1_r_valid_o  = rbusy_q & rgnt_q & s_r_valid_i;
  assign m0_r_o        = s_r_i;
  assign m1_r_o        = s_r_i;

  a_wgnt_free: assert property (@(posedge clk) disable iff (rst)
    $fell(wbusy_q) |-> s_aw_ready_i)
    else $error("write grant released before the slave was idle");

  a_rgnt_free: assert property (@(posedge clk) disable iff (rst)
    $fell(rbusy_q) |-> s_ar_ready_i)
    else $error("read grant released before the slave was idle");

endmodule

`default_nettype wire

// File: hw/mem_subsys_top.sv
`default_nettype none

module mem_subsys_top (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 m0_aw_valid_i,
  input  wire axi_mem_pkg::axi_aw_t m0_aw_i,
  output logic                      m0_aw_ready_o,
  input  wire logic                 m0_w_valid_i,
  input  wire axi_mem_pkg::axi_w_t  m0_w_i,
  output logic                      m0_w_ready_o,
  output logic                      m0_b_valid_o,
  output axi_mem_pkg::axi_b_t       m0_b_o,
  input  wire logic                 m0_b_ready_i,
  input  wire logic                 m0_ar_valid_i,
  input  wire axi_mem_pkg::axi_ar_t m0_ar_i,
  output logic                      m0_ar_ready_o,
  output logic                      m0_r_valid_o,
  output axi_mem_pkg::axi_r_t       m0_r_o,
  input  wire logic                 m0_r_ready_i,
  input  wire logic                 m1_aw_valid_i,
  input  wire axi_mem_pkg::axi_aw_t m1_aw_i,
  output logic                      m1_aw_ready_o,
  input  wire logic                 m1_w_valid_i,
  input  wire axi_mem_pkg::axi_w_t  m1_w_i,
  output logic                      m1_w_ready_o,
  output logic                      m1_b_valid_o,
  output axi_mem_pkg::axi_b_t       m1_b_o,
  input  wire logic                 m1_b_ready_i,
  input  wire logic                 m1_ar_valid_i,
  input  wire axi_mem_pkg::axi_ar_t m1_ar_i,
  output logic                      m1_ar_ready_o,
  output logic                      m1_r_valid_o,
  output axi_mem_pkg::axi_r_t       m1_r_o,
  input  wire logic                 m1_r_ready_i
);
  import axi_mem_pkg::*;

  // arbiter to slave
  logic    s_aw_valid, s_aw_ready;
  axi_aw_t s_aw;
  logic    s_w_valid, s_w_ready;
  axi_w_t  s_w;
  logic    s_b_valid, s_b_ready;
  axi_b_t  s_b;
  logic    s_ar_valid, s_ar_ready;
  axi_ar_t s_ar;
  logic    s_r_valid, s_r_ready;
  axi_r_t  s_r;

  axi_arbiter arb0 (
    .*,  // clk, rst and the master ports share names with the top
    .s_aw_valid_o(s_aw_valid),
    .s_aw_o      (s_aw),
    .s_aw_ready_i(s_aw_ready),
    .s_w_valid_o (s_w_valid),
    .s_w_o       (s_w),
    .s_w_ready_i (s_w_ready),
    .s_b_valid_i (s_b_valid),
    .s_b_i       (s_b),
    .s_b_ready_o (s_b_ready),
    .s_ar_valid_o(s_ar_valid),
    .s_ar_o      (s_ar),
    .s_ar_ready_i(s_ar_ready),
    .s_r_valid_i (s_r_valid),
    .s_r_i       (s_r),
    .s_r_ready_o (s_r_ready)
  );

  axi_sram_slave #(
    .DEPTH(MEM_WORDS)
  ) slave0 (
    .clk       (clk),
    .rst       (rst),
    .aw_valid_i(s_aw_valid),
    .aw_i      (s_aw),
    .aw_ready_o(s_aw_ready),
    .w_valid_i (s_w_valid),
    .w_i       (s_w),
    .w_ready_o (s_w_ready),
    .b_valid_o (s_b_valid),
    .b_o       (s_b),
    .b_ready_i (s_b_ready),
    .ar_valid_i(s_ar_valid),
    .ar_i      (s_ar),
    .ar_ready_o(s_ar_ready),
    .r_valid_o (s_r_valid),
    .r_o       (s_r),
    .r_ready_i (s_r_ready)
  );

endmodule

`default_nettype wire

// File: sim/tb_mem_subsys.sv
`default_nettype none

module tb_mem_subsys;
  timeunit 1ns;
  timeprecision 1ps;

  import axi_mem_pkg::*;

  localparam int TIMEOUT = 200;

  typedef logic [$clog2(MEM_WORDS)-1:0] word_idx_t;
  typedef enum {CH_AW, CH_W, CH_B, CH_AR, CH_R} chan_e;

  typedef struct {
    int        master;
    logic      wr;
    axi_addr_t addr;
    logic      len;
    axi_data_t d0;
    axi_data_t d1;
    axi_strb_t strb;
    axi_resp_e resp;
    logic      conc;   // runs alongside the next entry
    int        stall;  // cycles with b/r ready held low
  } op_t;

  logic       clk;
  logic       rst;
  logic [1:0] aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic [1:0] ar_valid, ar_ready, r_valid, r_ready;
  logic [1:0] wr_open, rd_open;
  axi_aw_t    aw [2];
  axi_w_t     w [2];
  axi_b_t     b [2];
  axi_ar_t    ar [2];
  axi_r_t     r [2];
  axi_data_t  model [MEM_WORDS];
  op_t        ops [$];

  mem_subsys_top dut0 (
    .clk(clk), .rst(rst),
    .m0_aw_valid_i(aw_valid[0]), .m0_aw_i(aw[0]), .m0_aw_ready_o(aw_ready[0]),
    .m0_w_valid_i(w_valid[0]), .m0_w_i(w[0]), .m0_w_ready_o(w_ready[0]),
    .m0_b_valid_o(b_valid[0]), .m0_b_o(b[0]), .m0_b_ready_i(b_ready[0]),
    .m0_ar_valid_i(ar_valid[0]), .m0_ar_i(ar[0]), .m0_ar_ready_o(ar_ready[0]),
    .m0_r_valid_o(r_valid[0]), .m0_r_o(r[0]), .m0_r_ready_i(r_ready[0]),
    .m1_aw_valid_i(aw_valid[1]), .m1_aw_i(aw[1]), .m1_aw_ready_o(aw_ready[1]),
    .m1_w_valid_i(w_valid[1]), .m1_w_i(w[1]), .m1_w_ready_o(w_ready[1]),
    .m1_b_valid_o(b_valid[1]), .m1_b_o(b[1]), .m1_b_ready_i(b_ready[1]),
    .m1_ar_valid_i(ar_valid[1]), .m1_ar_i(ar[1]), .m1_ar_ready_o(ar_ready[1]),
    .m1_r_valid_o(r_valid[1]), .m1_r_o(r[1]), .m1_r_ready_i(r_ready[1])
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_run(string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "testbench stopped on the first error");
  endtask

  task automatic check_resp(string name, axi_resp_e got, axi_resp_e exp);
    if (got !== exp) begin
      stop_run($sformatf("mismatch at %0t: %s got %s expected %s",
                         $time, name, got.name(), exp.name()));
    end
  endtask

  task automatic check_data(string name, axi_data_t got, axi_data_t exp);
    if (got !== exp) begin
      stop_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_last(string name, logic got, logic exp);
    if (got !== exp) begin
      stop_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  function automatic logic chan_sig(int m, chan_e ch);
    case (ch)
      CH_AW:   return aw_ready[m];
      CH_W:    return w_ready[m];
      CH_B:    return b_valid[m];
      CH_AR:   return ar_ready[m];
      default: return r_valid[m];
    endcase
  endfunction

  // returns at a falling edge with the signal high
  task automatic wait_high(int m, chan_e ch);
    int n;
    n = 0;
    @(negedge clk);
    while (chan_sig(m, ch) !== 1'b1) begin
      n++;
      if (n > TIMEOUT) begin
        stop_run($sformatf("timeout: master %0d waited %0d cycles on channel %s",
                           m, TIMEOUT, ch.name()));
      end
      @(negedge clk);
    end
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  // beats outside the array are dropped, the rest land byte by byte
  task automatic model_write(op_t op);
    axi_addr_t a;
    axi_data_t d;
    for (int beat = 0; beat <= int'(op.len); beat++) begin
      a = op.addr + BEAT_BYTES * axi_addr_t'(beat);
      d = (beat == 0) ? op.d0 : op.d1;
      if (a < axi_addr_t'(MEM_WORDS * AXI_STRB_W)) begin
        for (int k = 0; k < AXI_STRB_W; k++) begin
          if (op.strb[k]) begin
            model[word_idx_t'(a >> WORD_LSB)][k*8 +: 8] = d[k*8 +: 8];
          end
        end
      end
    end
  endtask

  task automatic axi_write(op_t op);
    int m;
    m = op.master;
    aw[m] = '{addr: op.addr, prot: 3'b000, len: op.len, size: 3'd3, burst: 2'b01};
    aw_valid[m] = 1'b1;
    wait_high(m, CH_AW);
    step();
    aw_valid[m] = 1'b0;
    for (int beat = 0; beat <= int'(op.len); beat++) begin
      w[m] = '{data: (beat == 0) ? op.d0 : op.d1, strb: op.strb,
               last: (beat == int'(op.len))};
      w_valid[m] = 1'b1;
      wait_high(m, CH_W);
      step();
    end
    w_valid[m] = 1'b0;
    wr_open[m] = 1'b1;
    wait_high(m, CH_B);
    step();
    repeat (op.stall) step();  // back-pressure on b
    b_ready[m] = 1'b1;
    wait_high(m, CH_B);
    check_resp($sformatf("m%0d b.resp", m), b[m].resp, op.resp);
    step();
    b_ready[m] = 1'b0;
    wr_open[m] = 1'b0;
    model_write(op);
  endtask

  task automatic axi_read(op_t op);
    int        m;
    axi_addr_t a;
    axi_data_t exp;
    m = op.master;
    ar[m] = '{addr: op.addr, prot: 3'b000, len: op.len, size: 3'd3, burst: 2'b01};
    ar_valid[m] = 1'b1;
    wait_high(m, CH_AR);
    step();
    ar_valid[m] = 1'b0;
    rd_open[m] = 1'b1;
    for (int beat = 0; beat <= int'(op.len); beat++) begin
      a = op.addr + BEAT_BYTES * axi_addr_t'(beat);
      exp = (op.resp == RESP_OKAY) ? model[word_idx_t'(a >> WORD_LSB)] : '0;
      wait_high(m, CH_R);
      step();
      repeat (op.stall) step();
      r_ready[m] = 1'b1;
      wait_high(m, CH_R);
      check_data($sformatf("m%0d r.data beat %0d", m, beat), r[m].data, exp);
      check_resp($sformatf("m%0d r.resp beat %0d", m, beat), r[m].resp, op.resp);
      check_last($sformatf("m%0d r.last beat %0d", m, beat), r[m].last,
                 (beat == int'(op.len)));
      step();
      r_ready[m] = 1'b0;
    end
    rd_open[m] = 1'b0;
  endtask

  task automatic run_op(op_t op);
    if (op.wr) begin
      axi_write(op);
    end else begin
      axi_read(op);
    end
  endtask

  task automatic add_op(int master, int wr, axi_addr_t addr, int len, axi_strb_t strb,
                        axi_resp_e resp, int conc, int bp);
    op_t o;
    o.master = master;
    o.wr     = (wr != 0);
    o.addr   = addr;
    o.len    = (len != 0);
    o.d0     = {$urandom, $urandom};
    o.d1     = {$urandom, $urandom};
    o.strb   = strb;
    o.resp   = resp;
    o.conc   = (conc != 0);
    o.stall  = (bp != 0) ? int'($urandom_range(6, 2)) : 0;
    ops.push_back(o);
  endtask

  // a master must never see a response for the other's transfer
  always @(negedge clk) begin
    if (!rst) begin
      for (int m = 0; m < 2; m++) begin
        if (b_valid[m] && !wr_open[m]) begin
          stop_run($sformatf("master %0d saw b_valid without a write of its own", m));
        end
        if (r_valid[m] && !rd_open[m]) begin
          stop_run($sformatf("master %0d saw r_valid without a read of its own", m));
        end
      end
    end
  end

  initial begin
    int i;
    void'($urandom(32'hfbb2_71ed));
    rst = 1'b1;
    aw_valid = '0;
    w_valid = '0;
    b_ready = '0;
    ar_valid = '0;
    r_ready = '0;
    wr_open = '0;
    rd_open = '0;
    for (int m = 0; m < 2; m++) begin
      aw[m] = '0;
      w[m] = '0;
      ar[m] = '0;
    end

    // master, write, address, len, strobe, resp, concurrent, back-pressure
    add_op(1, 1, 32'h0000_0000, 0, 8'hff, RESP_OKAY, 0, 0);
    add_op(1, 0, 32'h0000_0000, 0, 8'h00, RESP_OKAY, 0, 0);
    add_op(1, 1, 32'h0000_0040, 1, 8'hff, RESP_OKAY, 0, 0);
    add_op(1, 0, 32'h0000_0040, 1, 8'h00, RESP_OKAY, 0, 0);
    add_op(1, 1, 32'h0000_0040, 1, 8'h0f, RESP_OKAY, 0, 0);  // partial strobes
    add_op(1, 1, 32'h0000_0048, 0, 8'ha5, RESP_OKAY, 0, 0);
    add_op(1, 0, 32'h0000_0040, 1, 8'h00, RESP_OKAY, 0, 0);
    add_op(1, 1, 32'h0000_0800, 0, 8'hff, RESP_SLVERR, 0, 0);  // aliases word 0
    add_op(1, 0, 32'h0000_0800, 1, 8'h00, RESP_SLVERR, 0, 0);
    add_op(1, 1, 32'h0000_07f8, 1, 8'hff, RESP_SLVERR, 0, 0);  // second beat off the end
    add_op(1, 0, 32'h0000_0000, 0, 8'h00, RESP_OKAY, 0, 0);
    add_op(0, 0, 32'h0000_07f8, 0, 8'h00, RESP_OKAY, 0, 0);
    add_op(0, 1, 32'h0000_0100, 1, 8'hff, RESP_OKAY, 1, 0);
    add_op(1, 1, 32'h0000_0200, 1, 8'hff, RESP_OKAY, 0, 0);
    add_op(0, 0, 32'h0000_0100, 1, 8'h00, RESP_OKAY, 1, 0);
    add_op(1, 0, 32'h0000_0200, 1, 8'h00, RESP_OKAY, 0, 0);
    add_op(0, 1, 32'h0000_0300, 1, 8'hff, RESP_OKAY, 0, 1);
    add_op(0, 0, 32'h0000_0300, 1, 8'h00, RESP_OKAY, 0, 1);
    add_op(1, 1, 32'h1000_0000, 0, 8'hff, RESP_SLVERR, 1, 1);
    add_op(0, 1, 32'h0000_0308, 0, 8'h3c, RESP_OKAY, 0, 1);
    add_op(0, 0, 32'h0000_0300, 1, 8'h00, RESP_OKAY, 1, 1);
    add_op(1, 0, 32'h0000_0200, 1, 8'h00, RESP_OKAY, 0, 1);

    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    i = 0;
    while (i < ops.size()) begin
      if (ops[i].conc && (i + 1 < ops.size())) begin
        fork
          run_op(ops[i]);
          run_op(ops[i + 1]);
        join
        i += 2;
      end else begin
        run_op(ops[i]);
        i++;
      end
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
hw/axi_mem_pkg.sv
hw/sram_array.sv
hw/axi_sram_slave.sv
hw/axi_arbiter.sv
hw/mem_subsys_top.sv
sim/tb_mem_subsys.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_mem_subsys \
  -f src.f -o tb_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "simulator returned a nonzero status"
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || { echo "run ended without a result"; exit 1; }
exit 0
